// File: verilog/trafficPkg.sv
`default_nettype none

package trafficPkg;

	// phases of the two directions, north-south first
	typedef enum logic [2:0]
	{
		YY = 3'd0,
		RY = 3'd1,
		GR = 3'd2,
		YR = 3'd3,
		RG = 3'd4
	} phaseT;

	localparam int SecondsWidth = 4;
	localparam int TickWidth = 16;
	localparam int SegmentWidth = 7;
	localparam int LampWidth = 3;

	// dwell per phase in normal mode, order RY GR YR RG
	localparam logic [SecondsWidth-1:0] NormalDwell [4] =
		'{4'd3, 4'd15, 4'd3, 4'd10};

	// same dwell for every phase in test mode
	localparam logic [SecondsWidth-1:0] TestDwell = 4'd2;

	// 10 for simulation, a board build raises this to the real clock rate
	localparam logic [TickWidth-1:0] TicksPerSecond = 16'd10;
	localparam logic [TickWidth-1:0] LastTick = TicksPerSecond - 16'd1;

	// cycles each digit stays selected
	localparam int ScanTicks = 4;
	localparam int ScanCountWidth = $clog2(ScanTicks);

	// digit select encodings
	localparam logic [1:0] SelectUnits = 2'b01;
	localparam logic [1:0] SelectTens = 2'b10;

	// lamp bits are red, yellow, green
	localparam logic [LampWidth-1:0] LampRed = 3'b100;
	localparam logic [LampWidth-1:0] LampYellow = 3'b010;
	localparam logic [LampWidth-1:0] LampGreen = 3'b001;

	// active high segments, A is the msb
	function automatic logic [SegmentWidth-1:0] segmentOf(input logic [3:0] digit);
		logic [SegmentWidth-1:0] pattern;
		case (digit)
			4'd0: pattern = 7'b1111110;
			4'd1: pattern = 7'b0110000;
			4'd2: pattern = 7'b1101101;
			4'd3: pattern = 7'b1111001;
			4'd4: pattern = 7'b0110011;
			4'd5: pattern = 7'b1011011;
			4'd6: pattern = 7'b1011111;
			4'd7: pattern = 7'b1110010;
			4'd8: pattern = 7'b1111111;
			4'd9: pattern = 7'b1111011;
			// blank for anything that is not a decimal digit
			default: pattern = 7'b0000000;
		endcase
		return pattern;
	endfunction

endpackage

`default_nettype wire

// File: verilog/dwellTimer.sv
`timescale 1ns/1ps
`default_nettype none

module dwellTimer
	import trafficPkg::*;
(
	input wire clk,
	input wire reset,
	input wire load,
	input wire [SecondsWidth-1:0] loadSeconds,
	output logic [SecondsWidth-1:0] remaining,
	output logic expired
);

	logic [TickWidth-1:0] prescaler;
	logic running;
	logic secondTick;
	logic lastSecond;

	// nothing to count once the phase has run out
	assign running = (remaining != '0);

	// prescaler wraps once per second
	assign secondTick = running && (prescaler == LastTick);

	assign lastSecond = (remaining == SecondsWidth'(1));

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			prescaler <= '0;
		end
		else if (load)
		begin
			prescaler <= '0;
		end
		else if (secondTick)
		begin
			prescaler <= '0;
		end
		else if (running)
		begin
			prescaler <= prescaler + TickWidth'(1);
		end
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			remaining <= '0;
		end
		else if (load)
		begin
			remaining <= loadSeconds;
		end
		else if (secondTick)
		begin
			remaining <= remaining - SecondsWidth'(1);
		end
	end

	// one pulse, in the first cycle that shows zero
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			expired <= 1'b0;
		end
		else
		begin
			expired <= !load && secondTick && lastSecond;
		end
	end

endmodule

`default_nettype wire

// File: verilog/phaseController.sv
`timescale 1ns/1ps
`default_nettype none

module phaseController
	import trafficPkg::*;
(
	input wire clk,
	input wire reset,
	input wire standby,
	input wire testMode,
	input wire expired,
	output logic load,
	output logic [SecondsWidth-1:0] loadSeconds,
	output logic [LampWidth-1:0] nsLamp,
	output logic [LampWidth-1:0] ewLamp
);

	phaseT phase;
	phaseT advancePhase;
	phaseT nextPhase;
	logic [1:0] dwellIndex;

	// north-south lamp for a phase
	function automatic logic [LampWidth-1:0] nsLampOf(input phaseT p);
		logic [LampWidth-1:0] lamp;
		case (p)
			RY: lamp = LampRed;
			GR: lamp = LampGreen;
			YR: lamp = LampYellow;
			RG: lamp = LampRed;
			default: lamp = LampYellow;
		endcase
		return lamp;
	endfunction

	// east-west lamp for a phase
	function automatic logic [LampWidth-1:0] ewLampOf(input phaseT p);
		logic [LampWidth-1:0] lamp;
		case (p)
			RY: lamp = LampYellow;
			GR: lamp = LampRed;
			YR: lamp = LampRed;
			RG: lamp = LampGreen;
			default: lamp = LampYellow;
		endcase
		return lamp;
	endfunction

	// successor in the normal cycle, YY restarts at RY
	always_comb
	begin
		case (phase)
			YY: advancePhase = RY;
			RY: advancePhase = GR;
			GR: advancePhase = YR;
			YR: advancePhase = RG;
			RG: advancePhase = RY;
			default: advancePhase = RY;
		endcase
	end

	// leaving standby, or the current dwell has run out
	assign load = !standby && ((phase == YY) || expired);

	always_comb
	begin
		if (standby)
		begin
			nextPhase = YY;
		end
		else if (load)
		begin
			nextPhase = advancePhase;
		end
		else
		begin
			nextPhase = phase;
		end
	end

	// table order is RY GR YR RG
	always_comb
	begin
		case (advancePhase)
			RY: dwellIndex = 2'd0;
			GR: dwellIndex = 2'd1;
			YR: dwellIndex = 2'd2;
			default: dwellIndex = 2'd3;
		endcase
	end

	// testMode only matters here, at the load
	assign loadSeconds = testMode ? TestDwell : NormalDwell[dwellIndex];

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			phase <= YY;
		end
		else
		begin
			phase <= nextPhase;
		end
	end

	// lamps move together with the phase register
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			nsLamp <= LampYellow;
			ewLamp <= LampYellow;
		end
		else
		begin
			nsLamp <= nsLampOf(nextPhase);
			ewLamp <= ewLampOf(nextPhase);
		end
	end

endmodule

`default_nettype wire

// File: verilog/segmentScanner.sv
`timescale 1ns/1ps
`default_nettype none

module segmentScanner
	import trafficPkg::*;
(
	input wire clk,
	input wire reset,
	input wire [SecondsWidth-1:0] remaining,
	output logic [SegmentWidth-1:0] segments,
	output logic [1:0] digitSelect
);

	logic [ScanCountWidth-1:0] scanCount;
	logic scanWrap;
	logic [1:0] nextSelect;
	logic [3:0] tensDigit;
	logic [3:0] unitsDigit;
	logic [3:0] shownDigit;

	// remaining never goes past 15, so tens is 0 or 1
	always_comb
	begin
		if (remaining >= SecondsWidth'(10))
		begin
			tensDigit = 4'd1;
			unitsDigit = remaining - SecondsWidth'(10);
		end
		else
		begin
			tensDigit = 4'd0;
			unitsDigit = remaining;
		end
	end

	assign scanWrap = (scanCount == ScanCountWidth'(ScanTicks - 1));

	// free running, independent of the phase
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			scanCount <= '0;
		end
		else if (scanWrap)
		begin
			scanCount <= '0;
		end
		else
		begin
			scanCount <= scanCount + ScanCountWidth'(1);
		end
	end

	// swapping the two bits keeps exactly one of them set
	always_comb
	begin
		if (scanWrap)
		begin
			nextSelect = {digitSelect[0], digitSelect[1]};
		end
		else
		begin
			nextSelect = digitSelect;
		end
	end

	assign shownDigit = (nextSelect == SelectTens) ? tensDigit : unitsDigit;

	// select and pattern change on the same edge
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			digitSelect <= SelectUnits;
			segments <= segmentOf(4'd0);
		end
		else
		begin
			digitSelect <= nextSelect;
			segments <= segmentOf(shownDigit);
		end
	end

endmodule

`default_nettype wire

// File: verilog/trafficController.sv
`timescale 1ns/1ps
`default_nettype none

module trafficController
	import trafficPkg::*;
(
	input wire clk,
	input wire reset,
	input wire standby,
	input wire testMode,
	output logic [LampWidth-1:0] nsLamp,
	output logic [LampWidth-1:0] ewLamp,
	output logic [SegmentWidth-1:0] segments,
	output logic [1:0] digitSelect
);

	logic load;
	logic [SecondsWidth-1:0] loadSeconds;
	logic expired;
	logic [SecondsWidth-1:0] remaining;

	// phase FSM and lamp decode
	phaseController i_phaseController
	(
		.clk(clk),
		.reset(reset),
		.standby(standby),
		.testMode(testMode),
		.expired(expired),
		.load(load),
		.loadSeconds(loadSeconds),
		.nsLamp(nsLamp),
		.ewLamp(ewLamp)
	);

	// seconds left in the current phase
	dwellTimer i_dwellTimer
	(
		.clk(clk),
		.reset(reset),
		.load(load),
		.loadSeconds(loadSeconds),
		.remaining(remaining),
		.expired(expired)
	);

	// two digit countdown display
	segmentScanner i_segmentScanner
	(
		.clk(clk),
		.reset(reset),
		.remaining(remaining),
		.segments(segments),
		.digitSelect(digitSelect)
	);

endmodule

`default_nettype wire

// File: sim/trafficModel.svh
`ifndef trafficModelSvh
`define trafficModelSvh

// expected controller state stepped on every clock edge
phaseT modelPhase;
int modelRemaining;
int modelPrescaler;
logic modelExpired;
int modelScan;
logic [1:0] modelSelect;
logic [SegmentWidth-1:0] modelSegments;
logic [2*LampWidth-1:0] modelLamps;
int phaseDwell;
logic phaseTest;
int normalPhases;
int testPhases;
int standbyEntries;

function automatic phaseT successorOf(input phaseT p);
	case (p)
		RY: return GR;
		GR: return YR;
		YR: return RG;
		default: return RY;
	endcase
endfunction

function automatic int dwellFor(input phaseT p, input logic test);
	if (test)
		return int'(TestDwell);
	case (p)
		RY: return int'(NormalDwell[0]);
		GR: return int'(NormalDwell[1]);
		YR: return int'(NormalDwell[2]);
		default: return int'(NormalDwell[3]);
	endcase
endfunction

// north-south lamp in the upper half
function automatic logic [2*LampWidth-1:0] lampsOf(input phaseT p);
	case (p)
		RY: return {LampRed, LampYellow};
		GR: return {LampGreen, LampRed};
		YR: return {LampYellow, LampRed};
		RG: return {LampRed, LampGreen};
		default: return {LampYellow, LampYellow};
	endcase
endfunction

function automatic logic [SegmentWidth-1:0] patternOf(input int digit);
	case (digit)
		0: return 7'b1111110;
		1: return 7'b0110000;
		2: return 7'b1101101;
		3: return 7'b1111001;
		4: return 7'b0110011;
		5: return 7'b1011011;
		6: return 7'b1011111;
		7: return 7'b1110010;
		8: return 7'b1111111;
		9: return 7'b1111011;
		default: return 7'b0000000;
	endcase
endfunction

task automatic modelReset();
	modelPhase = YY;
	modelRemaining = 0;
	modelPrescaler = 0;
	modelExpired = 1'b0;
	modelScan = 0;
	modelSelect = 2'b01;
	modelSegments = patternOf(0);
	modelLamps = lampsOf(YY);
	phaseDwell = 0;
	phaseTest = 1'b0;
	normalPhases = 0;
	testPhases = 0;
	standbyEntries = 0;
endtask

task automatic modelStep(input logic standbyIn, input logic testIn);
	phaseT nextPhase;
	logic loadNow;
	logic tick;
	int shown;
	loadNow = !standbyIn && (modelPhase == YY || modelExpired);
	nextPhase = standbyIn ? YY : (loadNow ? successorOf(modelPhase) : modelPhase);
	tick = modelRemaining != 0 && modelPrescaler == int'(TicksPerSecond) - 1;
	if (loadNow && modelPhase != YY)
	begin
		if (phaseTest)
			testPhases++;
		else
			normalPhases++;
	end
	if (standbyIn && modelPhase != YY)
		standbyEntries++;
	// display shows the count of the cycle before
	if (modelScan == ScanTicks - 1)
		modelSelect = {modelSelect[0], modelSelect[1]};
	modelScan = (modelScan + 1) % ScanTicks;
	shown = (modelSelect == 2'b10) ? modelRemaining / 10 : modelRemaining % 10;
	modelSegments = patternOf(shown);
	modelExpired = !loadNow && tick && modelRemaining == 1;
	if (loadNow)
	begin
		phaseDwell = dwellFor(nextPhase, testIn);
		phaseTest = testIn;
		modelRemaining = phaseDwell;
		modelPrescaler = 0;
	end
	else if (tick)
	begin
		modelRemaining--;
		modelPrescaler = 0;
	end
	else if (modelRemaining != 0)
		modelPrescaler++;
	modelPhase = nextPhase;
	modelLamps = lampsOf(nextPhase);
endtask

`endif

// File: sim/trafficControllerTb.sv
`timescale 1ns/1ps
`default_nettype none

module trafficControllerTb
	import trafficPkg::*;
();

	logic clk;
	logic reset;
	logic standby;
	logic testMode;
	logic [LampWidth-1:0] nsLamp;
	logic [LampWidth-1:0] ewLamp;
	logic [SegmentWidth-1:0] segments;
	logic [1:0] digitSelect;
	logic [31:0] lfsr;
	logic [31:0] bits;
	int standbyLeft;
	int cycles;
	logic [2*LampWidth-1:0] shownLamps;
	int shownDwell;
	int lampCycles;

	trafficController i_trafficController
	(
		.clk(clk),
		.reset(reset),
		.standby(standby),
		.testMode(testMode),
		.nsLamp(nsLamp),
		.ewLamp(ewLamp),
		.segments(segments),
		.digitSelect(digitSelect)
	);

	task automatic stopOnFailure(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input int expected, input int actual);
		assert (expected == actual)
		else
			stopOnFailure($sformatf("ERR %0t %s expected %0h actual %0h",
				$time, name, expected, actual));
	endtask

	`include "trafficModel.svh"

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic drawBits(input int count, output logic [31:0] value);
		int i;
		value = '0;
		for (i = 0; i < count; i++)
		begin
			lfsr = lfsrNext(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk or negedge reset)
	begin
		if (!reset)
			modelReset();
		else
			modelStep(standby, testMode);
	end

	// outputs are settled by the falling edge
	always @(negedge clk)
	begin
		assert ($onehot(digitSelect))
		else
			stopOnFailure("digitSelect does not have exactly one bit set");
		checkValue("nsLamp", int'(modelLamps[2*LampWidth-1:LampWidth]), int'(nsLamp));
		checkValue("ewLamp", int'(modelLamps[LampWidth-1:0]), int'(ewLamp));
		checkValue("digitSelect", int'(modelSelect), int'(digitSelect));
		checkValue("segments", int'(modelSegments), int'(segments));
		// a phase that ran out lasts its dwell in seconds plus one cycle
		if (reset && {nsLamp, ewLamp} != shownLamps)
		begin
			if (shownLamps != lampsOf(YY) && {nsLamp, ewLamp} != lampsOf(YY))
				checkValue("phaseLength", shownDwell * int'(TicksPerSecond) + 1,
					lampCycles);
			lampCycles = 0;
		end
		lampCycles++;
		shownLamps = {nsLamp, ewLamp};
		shownDwell = phaseDwell;
	end

	initial
	begin
		reset = 1'b0;
		standby = 1'b0;
		testMode = 1'b0;
		lfsr = 32'h1977497a;
		standbyLeft = 0;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b1;
		// first edge out of reset should start RY
		cycles = 0;
		while (!(nsLamp == LampRed && ewLamp == LampYellow) && cycles < 5)
		begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!(nsLamp == LampRed && ewLamp == LampYellow))
			stopOnFailure("timeout waiting for the first RY phase after reset");
		checkValue("cyclesToRY", 1, cycles);
		for (int cycle = 0; cycle < 4000; cycle++)
		begin
			@(posedge clk);
			#1;
			if (cycle % 300 == 0)
			begin
				drawBits(1, bits);
				testMode = bits[0];
			end
			// rare standby pulses of one to four cycles
			if (standbyLeft > 0)
				standbyLeft = standbyLeft - 1;
			else
			begin
				drawBits(7, bits);
				if (bits == 32'd0)
				begin
					drawBits(2, bits);
					standbyLeft = int'(bits) + 1;
				end
			end
			standby = (standbyLeft > 0);
		end
		if (normalPhases > 0 && testPhases > 0 && standbyEntries > 0)
		begin
			$display("TEST OK");
			$finish;
		end
		else
			stopOnFailure("the run missed a normal phase, a test mode phase or a standby entry");
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+sim
verilog/trafficPkg.sv
verilog/dwellTimer.sv
verilog/phaseController.sv
verilog/segmentScanner.sv
verilog/trafficController.sv
sim/trafficControllerTb.sv

// File: Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = trafficControllerTb
FILELIST = verilog.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
